// ==== fma_pkg.sv ====
// ----------------------------------------
// FMA package
// Binary16 format constants, operation and rounding enums, status bits
// ----------------------------------------
package fma_pkg;

  // Binary16 encoding
  localparam int EXP_BITS  = 5;
  localparam int MAN_BITS  = 10;
  localparam int FP_WIDTH  = 16;
  localparam int BIAS      = 15;
  // Precision p including the implicit bit
  localparam int PREC_BITS = MAN_BITS + 1;

  // Internal datapath widths
  // Adder holds product, addend and round/sticky bits, 3p+4
  localparam int SUM_WIDTH       = 3 * PREC_BITS + 4;
  // Lower 2p+3 bits searched for cancellation
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  localparam int LZC_WIDTH       = 5;
  // Signed exponent with headroom for product and LZC
  localparam int EXP_WIDTH       = EXP_BITS + 2;
  localparam int SHAMT_WIDTH     = 6;

  // Canonical quiet NaN
  localparam logic [FP_WIDTH-1:0] QNAN = 16'h7E00;

  // Operation groups, op_mod flips the addend sign on top
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } fma_op_e;

  typedef enum logic [1:0] {
    RNE,
    RTZ,
    RDN,
    RUP
  } round_mode_e;

  // Status vector, NV at the top down to NX
  localparam int STATUS_W  = 5;
  localparam int STATUS_NV = 4;
  localparam int STATUS_DZ = 3;
  localparam int STATUS_OF = 2;
  localparam int STATUS_UF = 1;
  localparam int STATUS_NX = 0;

endpackage

// ==== fma_pipe_ctrl.sv ====
// ----------------------------------------
// FMA pipeline control
// Valid flags and load enables for stage 1 and the output register
// ----------------------------------------
`timescale 1ns/1ps

module fma_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  output logic out_valid_o,
  input  logic out_ready_i,
  output logic s1_en_o,
  output logic out_en_o
);

  logic s1_valid_q;
  logic out_valid_q;
  logic out_free;
  logic s1_ready;

  // Output register empty or being read this cycle
  assign out_free = ~out_valid_q | out_ready_i;

  // Stage 1 moves forward when it holds an item and the output can take it
  assign out_en_o = s1_valid_q & out_free;

  // Ready chain runs backward from out_ready_i
  assign s1_ready   = ~s1_valid_q | out_en_o;
  assign in_ready_o = s1_ready;
  assign s1_en_o    = in_valid_i & s1_ready;

  // ----------------------------------------
  // Valid flags
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      // Bubble or new item enters stage 1
      if (s1_ready) begin
        s1_valid_q <= in_valid_i;
      end
      if (out_free) begin
        out_valid_q <= s1_valid_q;
      end
    end
  end

  assign out_valid_o = out_valid_q;

endmodule

// ==== fma_operand_prep.sv ====
// ----------------------------------------
// FMA operand preparation
// Operation table, classification and special-case bypass into stage 1
// ----------------------------------------
`timescale 1ns/1ps

module fma_operand_prep import fma_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      s1_en_i,
  input  logic [2:0][FP_WIDTH-1:0]  operands_i,
  input  fma_op_e                   op_i,
  input  logic                      op_mod_i,
  input  round_mode_e               rnd_mode_i,
  output logic [FP_WIDTH-1:0]       op_a_o,
  output logic [FP_WIDTH-1:0]       op_b_o,
  output logic [FP_WIDTH-1:0]       op_c_o,
  output logic [2:0]                is_normal_o,
  output logic [2:0]                is_subnormal_o,
  output logic [2:0]                is_zero_o,
  output logic                      special_q_o,
  output logic [FP_WIDTH-1:0]       special_result_q_o,
  output logic [STATUS_W-1:0]       special_status_q_o,
  output round_mode_e               rnd_mode_q_o
);

  logic [2:0] exp_ones, exp_zero, man_zero, quiet_bit;
  logic [2:0] is_inf, is_nan, is_snan;
  logic       eff_sub;
  logic       special_d;
  logic [FP_WIDTH-1:0] special_result_d;
  logic [STATUS_W-1:0] special_status_d;

  // Field checks per operand
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      exp_ones[i]  = &operands_i[i][FP_WIDTH-2:MAN_BITS];
      exp_zero[i]  = ~|operands_i[i][FP_WIDTH-2:MAN_BITS];
      man_zero[i]  = ~|operands_i[i][MAN_BITS-1:0];
      quiet_bit[i] = operands_i[i][MAN_BITS-1];
    end
  end

  // ----------------------------------------
  // Operation table and classification
  // ----------------------------------------
  always_comb begin
    op_a_o         = operands_i[0];
    op_b_o         = operands_i[1];
    op_c_o         = operands_i[2];
    is_normal_o    = ~exp_ones & ~exp_zero;
    is_subnormal_o = exp_zero & ~man_zero;
    is_zero_o      = exp_zero & man_zero;
    is_inf         = exp_ones & man_zero;
    is_nan         = exp_ones & ~man_zero;
    is_snan        = exp_ones & ~man_zero & ~quiet_bit;
    // Modifier negates the addend in every group
    op_c_o[FP_WIDTH-1] = op_c_o[FP_WIDTH-1] ^ op_mod_i;
    unique case (op_i)
      FMADD: ;
      FNMSUB: op_a_o[FP_WIDTH-1] = ~op_a_o[FP_WIDTH-1];
      ADD: begin
        // Multiplicand becomes +1.0
        op_a_o            = {1'b0, EXP_BITS'(BIAS), {MAN_BITS{1'b0}}};
        is_normal_o[0]    = 1'b1;
        is_subnormal_o[0] = 1'b0;
        is_zero_o[0]      = 1'b0;
        is_inf[0]         = 1'b0;
        is_nan[0]         = 1'b0;
        is_snan[0]        = 1'b0;
      end
      MUL: begin
        // Zero addend, sign picked by rounding mode
        op_c_o            = {rnd_mode_i != RDN, {(FP_WIDTH-1){1'b0}}};
        is_normal_o[2]    = 1'b0;
        is_subnormal_o[2] = 1'b0;
        is_zero_o[2]      = 1'b1;
        is_inf[2]         = 1'b0;
        is_nan[2]         = 1'b0;
        is_snan[2]        = 1'b0;
      end
    endcase
  end

  assign eff_sub = op_a_o[FP_WIDTH-1] ^ op_b_o[FP_WIDTH-1] ^ op_c_o[FP_WIDTH-1];

  // ----------------------------------------
  // Special cases in priority order
  // ----------------------------------------
  always_comb begin
    special_d        = 1'b0;
    special_result_d = QNAN;
    special_status_d = '0;
    // inf * 0 is invalid even with a quiet NaN addend
    if ((is_inf[0] & is_zero_o[1]) | (is_zero_o[0] & is_inf[1])) begin
      special_d                   = 1'b1;
      special_status_d[STATUS_NV] = 1'b1;
    end else if (|is_nan) begin
      special_d                   = 1'b1;
      special_status_d[STATUS_NV] = |is_snan;
    end else if (|is_inf) begin
      special_d = 1'b1;
      if ((is_inf[0] | is_inf[1]) & is_inf[2] & eff_sub) begin
        // Opposite infinities cancel
        special_status_d[STATUS_NV] = 1'b1;
      end else if (is_inf[0] | is_inf[1]) begin
        special_result_d = {op_a_o[FP_WIDTH-1] ^ op_b_o[FP_WIDTH-1],
                            {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end else begin
        special_result_d = {op_c_o[FP_WIDTH-1], {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end
    end
  end

  // Stage-1 registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      special_q_o <= 1'b0;
    end else if (s1_en_i) begin
      special_q_o <= special_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_en_i) begin
      special_result_q_o <= special_result_d;
      special_status_q_o <= special_status_d;
      rnd_mode_q_o       <= rnd_mode_i;
    end
  end

endmodule

// ==== fma_align_add.sv ====
// ----------------------------------------
// FMA exponent, product and addend path
// Aligns the addend to the product and adds, registered into stage 1
// ----------------------------------------
`timescale 1ns/1ps

module fma_align_add import fma_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          s1_en_i,
  input  logic [FP_WIDTH-1:0]           op_a_i,
  input  logic [FP_WIDTH-1:0]           op_b_i,
  input  logic [FP_WIDTH-1:0]           op_c_i,
  input  logic [2:0]                    is_normal_i,
  input  logic [2:0]                    is_subnormal_i,
  input  logic [2:0]                    is_zero_i,
  output logic                          eff_sub_q_o,
  output logic signed [EXP_WIDTH-1:0]   exp_prod_q_o,
  output logic signed [EXP_WIDTH-1:0]   exp_diff_q_o,
  output logic signed [EXP_WIDTH-1:0]   tent_exp_q_o,
  output logic [SHAMT_WIDTH-1:0]        shamt_q_o,
  output logic                          sticky_q_o,
  output logic [SUM_WIDTH-1:0]          sum_q_o,
  output logic                          sign_q_o
);

  logic signed [EXP_WIDTH-1:0] exp_a, exp_b, exp_c;
  logic signed [EXP_WIDTH-1:0] exp_addend, exp_prod, exp_diff, tent_exp;
  logic [SHAMT_WIDTH-1:0]      shamt;
  logic                        eff_sub, tent_sign, final_sign;
  logic [PREC_BITS-1:0]        man_a, man_b, man_c;
  logic [2*PREC_BITS-1:0]      product;
  logic [SUM_WIDTH-1:0]        product_shifted;
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;
  logic [SUM_WIDTH-1:0]        addend_aligned, addend_inv;
  logic                        sticky;
  logic [SUM_WIDTH:0]          sum_raw;
  logic [SUM_WIDTH-1:0]        sum;

  // ----------------------------------------
  // Exponents, kept biased
  // ----------------------------------------
  assign exp_a = {{(EXP_WIDTH-EXP_BITS){1'b0}}, op_a_i[FP_WIDTH-2:MAN_BITS]};
  assign exp_b = {{(EXP_WIDTH-EXP_BITS){1'b0}}, op_b_i[FP_WIDTH-2:MAN_BITS]};
  assign exp_c = {{(EXP_WIDTH-EXP_BITS){1'b0}}, op_c_i[FP_WIDTH-2:MAN_BITS]};

  // Subnormal or zero addend sits at exponent 1
  assign exp_addend = exp_c + EXP_WIDTH'(!is_normal_i[2]);
  // Zero product gets the minimum exponent
  assign exp_prod = (is_zero_i[0] | is_zero_i[1]) ? EXP_WIDTH'(2 - BIAS)
                  : exp_a + exp_b + EXP_WIDTH'(is_subnormal_i[0])
                    + EXP_WIDTH'(is_subnormal_i[1]) - EXP_WIDTH'(BIAS);
  assign exp_diff = exp_addend - exp_prod;
  assign tent_exp = (exp_diff > 0) ? exp_addend : exp_prod;

  // Addend right shift, saturated at both ends
  always_comb begin
    if (exp_diff <= -2 * PREC_BITS - 1) begin
      // Addend lands in the sticky bit only
      shamt = SHAMT_WIDTH'(3 * PREC_BITS + 4);
    end else if (exp_diff <= PREC_BITS + 2) begin
      shamt = SHAMT_WIDTH'(PREC_BITS + 3 - exp_diff);
    end else begin
      shamt = '0;
    end
  end

  // ----------------------------------------
  // Product and addend alignment
  // ----------------------------------------
  assign man_a = {is_normal_i[0], op_a_i[MAN_BITS-1:0]};
  assign man_b = {is_normal_i[1], op_b_i[MAN_BITS-1:0]};
  assign man_c = {is_normal_i[2], op_c_i[MAN_BITS-1:0]};

  assign product = man_a * man_b;
  // Product sits above the round and sticky positions
  assign product_shifted = SUM_WIDTH'(product) << 2;

  // Up to p bits fall off the right end into the sticky bit
  assign addend_wide    = {man_c, {SUM_WIDTH{1'b0}}} >> shamt;
  assign addend_aligned = addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  assign sticky         = |addend_wide[PREC_BITS-1:0];

  assign eff_sub    = op_a_i[FP_WIDTH-1] ^ op_b_i[FP_WIDTH-1] ^ op_c_i[FP_WIDTH-1];
  assign tent_sign  = op_a_i[FP_WIDTH-1] ^ op_b_i[FP_WIDTH-1];
  assign addend_inv = eff_sub ? ~addend_aligned : addend_aligned;

  // Carry-in completes the two's complement unless sticky bits were lost
  assign sum_raw = product_shifted + addend_inv + SUM_WIDTH'(eff_sub & ~sticky);

  // No carry on subtraction means a negative sum
  assign sum = (eff_sub && !sum_raw[SUM_WIDTH]) ? SUM_WIDTH'(-sum_raw) : sum_raw[SUM_WIDTH-1:0];
  assign final_sign = eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;

  // Stage-1 registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eff_sub_q_o <= 1'b0;
    end else if (s1_en_i) begin
      eff_sub_q_o <= eff_sub;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_en_i) begin
      exp_prod_q_o <= exp_prod;
      exp_diff_q_o <= exp_diff;
      tent_exp_q_o <= tent_exp;
      shamt_q_o    <= shamt;
      sticky_q_o   <= sticky;
      sum_q_o      <= sum;
      sign_q_o     <= final_sign;
    end
  end

endmodule

// ==== fma_normalize.sv ====
// ----------------------------------------
// FMA normalization
// Leading-zero count and shifts of the stage-1 sum
// ----------------------------------------
`timescale 1ns/1ps

module fma_normalize import fma_pkg::*; (
  input  logic                          eff_sub_i,
  input  logic signed [EXP_WIDTH-1:0]   exp_prod_i,
  input  logic signed [EXP_WIDTH-1:0]   exp_diff_i,
  input  logic signed [EXP_WIDTH-1:0]   tent_exp_i,
  input  logic [SHAMT_WIDTH-1:0]        shamt_i,
  input  logic                          sticky_i,
  input  logic [SUM_WIDTH-1:0]          sum_i,
  output logic signed [EXP_WIDTH-1:0]   final_exp_o,
  output logic [PREC_BITS:0]            final_man_o,
  output logic                          sticky_o
);

  logic [LZC_WIDTH-1:0]          lzc;
  logic                          lzc_empty;
  logic signed [EXP_WIDTH-1:0]   lzc_sgn;
  logic signed [EXP_WIDTH-1:0]   exp_cand, norm_exp;
  logic [SHAMT_WIDTH-1:0]        norm_shamt;
  logic [SUM_WIDTH:0]            sum_shifted;
  logic [LOWER_SUM_WIDTH-1:0]    sum_sticky_bits;

  // Priority search, the highest set bit wins
  always_comb begin
    lzc       = '0;
    lzc_empty = 1'b1;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (sum_i[i]) begin
        lzc       = LZC_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
        lzc_empty = 1'b0;
      end
    end
  end

  assign lzc_sgn  = signed'(EXP_WIDTH'(lzc));
  assign exp_cand = exp_prod_i - lzc_sgn + 1;

  // ----------------------------------------
  // Large shift selection
  // ----------------------------------------
  always_comb begin
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      if ((exp_cand >= 0) && !lzc_empty) begin
        // Product anchored, drop the counted zeros
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + lzc);
        norm_exp   = exp_cand;
      end else begin
        // Subnormal, shift capped at the minimum exponent
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + exp_prod_i);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // One-bit correction, leading one may sit either side of the MSB
  always_comb begin
    {final_man_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp_o                    = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      // Carry out, move right
      {final_man_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp_o                    = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp_o = norm_exp;
    end else if (norm_exp > 1) begin
      {final_man_o, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp_o                    = norm_exp - 1;
    end else begin
      final_exp_o = '0;
    end
  end

  assign sticky_o = (|sum_sticky_bits) | sticky_i;

endmodule

// ==== fma_round.sv ====
// ----------------------------------------
// FMA rounding and output register
// Mode rounding, IEEE flags, special-result selection
// ----------------------------------------
`timescale 1ns/1ps

module fma_round import fma_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          out_en_i,
  input  logic                          sign_i,
  input  logic                          eff_sub_i,
  input  logic signed [EXP_WIDTH-1:0]   final_exp_i,
  input  logic [PREC_BITS:0]            final_man_i,
  input  logic                          sticky_i,
  input  round_mode_e                   rnd_mode_i,
  input  logic                          special_i,
  input  logic [FP_WIDTH-1:0]           special_result_i,
  input  logic [STATUS_W-1:0]           special_status_i,
  output logic [FP_WIDTH-1:0]           result_o,
  output logic [STATUS_W-1:0]           status_o
);

  logic                         of_before, of_after, uf_after;
  logic [FP_WIDTH-2:0]          pre_abs, rounded_abs;
  logic [1:0]                   rs_bits;
  logic                         round_up, exact_zero, rounded_sign;
  logic [STATUS_W-1:0]          regular_status;

  // Saturate to the largest finite value on overflow
  assign of_before = final_exp_i >= 2**EXP_BITS - 1;
  assign pre_abs   = of_before ? {EXP_BITS'(2**EXP_BITS - 2), {MAN_BITS{1'b1}}}
                               : {final_exp_i[EXP_BITS-1:0], final_man_i[MAN_BITS:1]};
  // Overflow forces round and sticky so the mode decides
  assign rs_bits   = of_before ? 2'b11 : {final_man_i[0], sticky_i};

  // ----------------------------------------
  // Rounding by mode
  // ----------------------------------------
  always_comb begin
    unique case (rnd_mode_i)
      RNE: round_up = rs_bits[1] & (rs_bits[0] | pre_abs[0]);
      RTZ: round_up = 1'b0;
      RDN: round_up = (|rs_bits) & sign_i;
      RUP: round_up = (|rs_bits) & ~sign_i;
    endcase
  end

  assign rounded_abs = pre_abs + (FP_WIDTH-1)'(round_up);

  // Exact zero from cancellation is +0, or -0 when rounding down
  assign exact_zero   = (pre_abs == '0) && (rs_bits == 2'b00);
  assign rounded_sign = (exact_zero && eff_sub_i) ? (rnd_mode_i == RDN) : sign_i;

  assign of_after = &rounded_abs[FP_WIDTH-2:MAN_BITS];
  assign uf_after = ~|rounded_abs[FP_WIDTH-2:MAN_BITS];

  // Flags, tininess checked after rounding
  always_comb begin
    regular_status            = '0;
    regular_status[STATUS_OF] = of_before | of_after;
    regular_status[STATUS_NX] = (|rs_bits) | of_before | of_after;
    regular_status[STATUS_UF] = uf_after & regular_status[STATUS_NX];
  end

  // Output register
  always_ff @(posedge clk_i) begin
    if (out_en_i) begin
      result_o <= special_i ? special_result_i : {rounded_sign, rounded_abs};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      status_o <= '0;
    end else if (out_en_i) begin
      status_o <= special_i ? special_status_i : regular_status;
    end
  end

endmodule

// ==== fma_top.sv ====
// ----------------------------------------
// Binary16 fused multiply-add, two stages
// ----------------------------------------
`timescale 1ns/1ps

module fma_top import fma_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic [2:0][FP_WIDTH-1:0]  operands_i,
  input  fma_op_e                   op_i,
  input  logic                      op_mod_i,
  input  round_mode_e               rnd_mode_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [FP_WIDTH-1:0]       result_o,
  output logic [STATUS_W-1:0]       status_o
);

  logic s1_en, out_en;

  // Operand prep to align/add, unregistered
  logic [FP_WIDTH-1:0] op_a, op_b, op_c;
  logic [2:0]          is_normal, is_subnormal, is_zero;

  // Stage 1
  logic                         special_q;
  logic [FP_WIDTH-1:0]          special_result_q;
  logic [STATUS_W-1:0]          special_status_q;
  round_mode_e                  rnd_mode_q;
  logic                         eff_sub_q, sticky_q, sign_q;
  logic signed [EXP_WIDTH-1:0]  exp_prod_q, exp_diff_q, tent_exp_q;
  logic [SHAMT_WIDTH-1:0]       shamt_q;
  logic [SUM_WIDTH-1:0]         sum_q;

  // Normalized value
  logic signed [EXP_WIDTH-1:0]  final_exp;
  logic [PREC_BITS:0]           final_man;
  logic                         final_sticky;

  fma_pipe_ctrl i_ctrl (
    .clk_i, .rst_n_i, .in_valid_i, .in_ready_o, .out_valid_o, .out_ready_i,
    .s1_en_o  (s1_en),
    .out_en_o (out_en)
  );

  fma_operand_prep i_prep (
    .clk_i, .rst_n_i, .operands_i, .op_i, .op_mod_i, .rnd_mode_i,
    .s1_en_i            (s1_en),
    .op_a_o             (op_a),
    .op_b_o             (op_b),
    .op_c_o             (op_c),
    .is_normal_o        (is_normal),
    .is_subnormal_o     (is_subnormal),
    .is_zero_o          (is_zero),
    .special_q_o        (special_q),
    .special_result_q_o (special_result_q),
    .special_status_q_o (special_status_q),
    .rnd_mode_q_o       (rnd_mode_q)
  );

  fma_align_add i_align (
    .clk_i, .rst_n_i,
    .s1_en_i        (s1_en),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .op_c_i         (op_c),
    .is_normal_i    (is_normal),
    .is_subnormal_i (is_subnormal),
    .is_zero_i      (is_zero),
    .eff_sub_q_o    (eff_sub_q),
    .exp_prod_q_o   (exp_prod_q),
    .exp_diff_q_o   (exp_diff_q),
    .tent_exp_q_o   (tent_exp_q),
    .shamt_q_o      (shamt_q),
    .sticky_q_o     (sticky_q),
    .sum_q_o        (sum_q),
    .sign_q_o       (sign_q)
  );

  fma_normalize i_norm (
    .eff_sub_i   (eff_sub_q),
    .exp_prod_i  (exp_prod_q),
    .exp_diff_i  (exp_diff_q),
    .tent_exp_i  (tent_exp_q),
    .shamt_i     (shamt_q),
    .sticky_i    (sticky_q),
    .sum_i       (sum_q),
    .final_exp_o (final_exp),
    .final_man_o (final_man),
    .sticky_o    (final_sticky)
  );

  fma_round i_round (
    .clk_i, .rst_n_i, .result_o, .status_o,
    .out_en_i         (out_en),
    .sign_i           (sign_q),
    .eff_sub_i        (eff_sub_q),
    .final_exp_i      (final_exp),
    .final_man_i      (final_man),
    .sticky_i         (final_sticky),
    .rnd_mode_i       (rnd_mode_q),
    .special_i        (special_q),
    .special_result_i (special_result_q),
    .special_status_i (special_status_q)
  );

endmodule

// ==== fma_chk.sv ====
// ----------------------------------------
// FMA handshake checker, bound to fma_top
// ----------------------------------------
`timescale 1ns/1ps

module fma_chk import fma_pkg::*; (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                out_valid_i,
  input logic                out_ready_i,
  input logic [FP_WIDTH-1:0] result_i,
  input logic [STATUS_W-1:0] status_i
);

  // Failure count read back by the testbench
  int unsigned assert_fails = 0;

  // Stalled output keeps valid and data
  hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i) && $stable(status_i))
    else begin
      $error("output valid or data changed while out_ready was low");
      assert_fails++;
    end

  // Pipeline needs two edges before a result can appear
  reset_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !out_valid_i ##1 !out_valid_i)
    else begin
      $error("out_valid rose too early after reset release");
      assert_fails++;
    end

  // No division here
  dz_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) !status_i[STATUS_DZ])
    else begin
      $error("DZ flag set on an FMA result");
      assert_fails++;
    end

endmodule

bind fma_top fma_chk i_chk (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    (result_o),
  .status_i    (status_o)
);

// ==== fma_tb.sv ====
// ----------------------------------------
// FMA testbench
// Stimulus table with random output back-pressure
// ----------------------------------------
`timescale 1ns/1ps

module fma_tb import fma_pkg::*; ();

  localparam int          DRIVE_DELAY = 10;
  localparam int          WAIT_LIMIT  = 200;
  localparam logic [31:0] LCG_SEED    = 32'h22869014;

  // One table entry, expected values worked by hand
  typedef struct {
    logic [FP_WIDTH-1:0] a;
    logic [FP_WIDTH-1:0] b;
    logic [FP_WIDTH-1:0] c;
    fma_op_e             op;
    logic                op_mod;
    round_mode_e         rm;
    logic [FP_WIDTH-1:0] exp_result;
    logic [STATUS_W-1:0] exp_status;
  } vec_t;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic [2:0][FP_WIDTH-1:0]  operands_i;
  fma_op_e                   op_i;
  logic                      op_mod_i;
  round_mode_e               rnd_mode_i;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic [FP_WIDTH-1:0]       result_o;
  logic [STATUS_W-1:0]       status_o;

  vec_t        vecs[$];
  int unsigned err_count;
  int unsigned timeout_count;
  int unsigned done_count;
  int unsigned chk_fails;
  logic [31:0] lcg_state;

  fma_top i_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .operands_i  (operands_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o)
  );

  // 100 ns clock
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_vec(input logic [15:0] a, input logic [15:0] b, input logic [15:0] c,
                         input fma_op_e op, input logic op_mod, input round_mode_e rm,
                         input logic [15:0] res, input logic [4:0] st);
    vec_t v;
    v.a          = a;
    v.b          = b;
    v.c          = c;
    v.op         = op;
    v.op_mod     = op_mod;
    v.rm         = rm;
    v.exp_result = res;
    v.exp_status = st;
    vecs.push_back(v);
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_table();
    // Exact FMADD, 2*3+1 and cancellation to signed zero
    add_vec(16'h4000, 16'h4200, 16'h3C00, FMADD, 1'b0, RNE, 16'h4700, 5'h00);
    add_vec(16'h3E00, 16'h4000, 16'h4200, FMADD, 1'b1, RNE, 16'h0000, 5'h00);
    add_vec(16'h3E00, 16'h4000, 16'h4200, FMADD, 1'b1, RDN, 16'h8000, 5'h00);
    // FMSUB, FNMSUB, FNMADD on 2*3 and 1
    add_vec(16'h4000, 16'h4200, 16'h3C00, FMADD, 1'b1, RNE, 16'h4500, 5'h00);
    add_vec(16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b0, RNE, 16'hC500, 5'h00);
    add_vec(16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b1, RNE, 16'hC700, 5'h00);
    // ADD and SUB ignore operand a
    add_vec(16'h1234, 16'h4000, 16'h4200, ADD, 1'b0, RNE, 16'h4500, 5'h00);
    add_vec(16'h1234, 16'h4000, 16'h4200, ADD, 1'b1, RNE, 16'hBC00, 5'h00);
    // MUL ignores operand c, negative products keep their sign
    add_vec(16'h4000, 16'hC200, 16'h3C00, MUL, 1'b0, RNE, 16'hC600, 5'h00);
    add_vec(16'hC000, 16'h4200, 16'h3C00, MUL, 1'b0, RDN, 16'hC600, 5'h00);
    // 1 + 2^-11 + 2^-14 in all four modes
    add_vec(16'h0000, 16'h3C00, 16'h1080, ADD, 1'b0, RNE, 16'h3C01, 5'h01);
    add_vec(16'h0000, 16'h3C00, 16'h1080, ADD, 1'b0, RTZ, 16'h3C00, 5'h01);
    add_vec(16'h0000, 16'h3C00, 16'h1080, ADD, 1'b0, RDN, 16'h3C00, 5'h01);
    add_vec(16'h0000, 16'h3C00, 16'h1080, ADD, 1'b0, RUP, 16'h3C01, 5'h01);
    // Specials: inf*0+qNaN, sNaN, inf-inf, inf product, inf addend
    add_vec(16'h7C00, 16'h0000, 16'h7E00, FMADD, 1'b0, RNE, 16'h7E00, 5'h10);
    add_vec(16'h3C00, 16'h7D00, 16'h3C00, FMADD, 1'b0, RNE, 16'h7E00, 5'h10);
    add_vec(16'h7C00, 16'h3C00, 16'h7C00, FMADD, 1'b1, RNE, 16'h7E00, 5'h10);
    add_vec(16'hFC00, 16'h4000, 16'h3C00, FMADD, 1'b0, RNE, 16'hFC00, 5'h00);
    add_vec(16'h3C00, 16'h3C00, 16'h7C00, FNMSUB, 1'b0, RNE, 16'h7C00, 5'h00);
    // Overflow of 65504*2, then a tiny inexact product
    add_vec(16'h7BFF, 16'h4000, 16'h0000, MUL, 1'b0, RNE, 16'h7C00, 5'h05);
    add_vec(16'h7BFF, 16'h4000, 16'h0000, MUL, 1'b0, RTZ, 16'h7BFF, 5'h05);
    add_vec(16'h0403, 16'h3400, 16'h0000, MUL, 1'b0, RNE, 16'h0101, 5'h03);
  endtask

  task automatic drive_requests();
    int cycles;
    bit accepted;
    for (int i = 0; i < vecs.size(); i++) begin
      operands_i = {vecs[i].c, vecs[i].b, vecs[i].a};
      op_i       = vecs[i].op;
      op_mod_i   = vecs[i].op_mod;
      rnd_mode_i = vecs[i].rm;
      in_valid_i = 1'b1;
      cycles     = 0;
      accepted   = 1'b0;
      // Ready sampled mid-cycle, the transfer lands on the next edge
      while (!accepted && cycles < WAIT_LIMIT) begin
        @(negedge clk_i);
        accepted = in_ready_o;
        cycles++;
      end
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (!accepted) begin
        $display("Timeout: request %0d was never accepted by the DUT", i);
        timeout_count++;
        break;
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic check_response(input int idx);
    bit ok;
    ok = 1'b1;
    assert (result_o === vecs[idx].exp_result) else begin
      $display("FAIL test %0d: result_o = %h, expected %h", idx, result_o,
               vecs[idx].exp_result);
      ok = 1'b0;
      err_count++;
    end
    assert (status_o === vecs[idx].exp_status) else begin
      $display("FAIL test %0d: status_o = %h, expected %h", idx, status_o,
               vecs[idx].exp_status);
      ok = 1'b0;
      err_count++;
    end
    done_count++;
    $display("Test %0d %s", idx, ok ? "ok" : "mismatch");
  endtask

  // ----------------------------------------
  // Response side with random stalls
  // ----------------------------------------
  task automatic collect_responses();
    int cycles;
    bit got;
    for (int i = 0; i < vecs.size(); i++) begin
      cycles = 0;
      got    = 1'b0;
      while (!got && cycles < WAIT_LIMIT) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
        lcg_state   = lcg_next(lcg_state);
        // Ready about three cycles in four
        out_ready_i = (lcg_state[31:30] != 2'b00);
        @(negedge clk_i);
        got = out_valid_o & out_ready_i;
        cycles++;
      end
      if (!got) begin
        $display("Timeout: no response arrived for test %0d", i);
        timeout_count++;
        break;
      end
      check_response(i);
    end
  endtask

  // Nothing may follow the last response
  task automatic check_drain();
    repeat (4) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      out_ready_i = 1'b1;
      @(negedge clk_i);
      assert (!out_valid_o) else begin
        $display("Extra response seen after the last test");
        err_count++;
      end
    end
  endtask

  initial begin
    rst_n_i       = 1'b0;
    in_valid_i    = 1'b0;
    operands_i    = '0;
    op_i          = FMADD;
    op_mod_i      = 1'b0;
    rnd_mode_i    = RNE;
    out_ready_i   = 1'b0;
    err_count     = 0;
    timeout_count = 0;
    done_count    = 0;
    lcg_state     = LCG_SEED;
    build_table();
    repeat (16) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    fork
      drive_requests();
      collect_responses();
    join
    check_drain();
    chk_fails = i_dut.i_chk.assert_fails;
    $display("Summary: %0d of %0d tests done, %0d errors, %0d timeouts, %0d assertion failures",
             done_count, vecs.size(), err_count, timeout_count, chk_fails);
    if (err_count == 0 && timeout_count == 0 && chk_fails == 0 && done_count == vecs.size()) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
fma_pkg.sv
fma_pipe_ctrl.sv
fma_operand_prep.sv
fma_align_add.sv
fma_normalize.sv
fma_round.sv
fma_top.sv
fma_chk.sv
fma_tb.sv

// ==== Bender.yml ====
package:
  name: fma_fp16

sources:
  - fma_pkg.sv
  - fma_pipe_ctrl.sv
  - fma_operand_prep.sv
  - fma_align_add.sv
  - fma_normalize.sv
  - fma_round.sv
  - fma_top.sv
  - target: simulation
    files:
      - fma_chk.sv
      - fma_tb.sv
